// File: src/sifh_params.svh
`ifndef SIFH_PARAMS_SVH
`define SIFH_PARAMS_SVH

// timestamp from the TDC
`define SIFH_TS_W 12

// bin index, 64 bins per histogram
`define SIFH_BIN_W 6

// bin count width, saturating at all ones
`define SIFH_CNT_W 6

// stamps consumed by each build pass
`define SIFH_PASS_LEN 64

`endif

// File: src/sifhPkg.sv
`include "sifh_params.svh"

package sifhPkg;

    typedef enum logic {
        opClear,                                // zero every bin
        opBuild                                 // count one pass of stamps
    } histOp_t;

    typedef enum logic [3:0] {
        sIdle,
        sClear0,
        sBuild0,
        sScan0,
        sWindow,
        sClear1,
        sBuild1,
        sScan1,
        sResult
    } ctrlState_t;

    typedef struct packed {
        histOp_t                op;
        logic                   fine;           // bin from low stamp bits
        logic [`SIFH_BIN_W-1:0] window;         // coarse bin kept in fine mode
    } histCmd_t;

    typedef struct packed {
        logic                   en;
        logic [`SIFH_BIN_W-1:0] addr;
        logic [`SIFH_CNT_W-1:0] data;
    } ramWr_t;

    typedef struct packed {
        logic [`SIFH_TS_W-1:0]  peakTime;       // coarse peak, then fine peak
        logic [`SIFH_CNT_W-1:0] peakCount;      // count of the fine peak
        logic [`SIFH_CNT_W-1:0] coarseCount;    // count of the coarse peak
    } peakResult_t;

endpackage

// File: src/histRam.sv
`timescale 1ns/1ps
`include "sifh_params.svh"

module histRam import sifhPkg::*; (
    input  logic                   clk,
    input  ramWr_t                 wr,
    input  logic [`SIFH_BIN_W-1:0] rdAddrA,
    input  logic [`SIFH_BIN_W-1:0] rdAddrB,
    output logic [`SIFH_CNT_W-1:0] rdDataA,
    output logic [`SIFH_CNT_W-1:0] rdDataB
);

    localparam int Bins = 1 << `SIFH_BIN_W;

    logic [`SIFH_CNT_W-1:0] mem [0:Bins-1];

    always_ff @(posedge clk) begin
        if (wr.en) begin
            mem[wr.addr] <= wr.data;
        end
    end

    // both reads registered, old data on a same-cycle write
    always_ff @(posedge clk) begin
        rdDataA <= mem[rdAddrA];               // builder side
        rdDataB <= mem[rdAddrB];               // scan side
    end

endmodule

// File: src/histBuilder.sv
`timescale 1ns/1ps
`include "sifh_params.svh"

module histBuilder import sifhPkg::*; (
    input  logic                   clk,
    input  logic                   res,
    input  logic                   histStart,
    input  histCmd_t               histCmd,
    output logic                   histDone,
    input  logic                   tdcReq,
    input  logic [`SIFH_TS_W-1:0]  tdcData,
    output logic                   tdcAck,
    output ramWr_t                 wr,
    output logic [`SIFH_BIN_W-1:0] rdAddr,
    input  logic [`SIFH_CNT_W-1:0] rdData
);

    localparam int StampW = $clog2(`SIFH_PASS_LEN + 1);
    localparam logic [StampW-1:0] PassLen = StampW'(`SIFH_PASS_LEN);
    localparam logic [`SIFH_CNT_W-1:0] CntMax = '1;

    logic                   clearing;
    logic                   building;
    logic                   idle;
    logic                   accept;
    logic                   inWindow;
    logic                   fineMode;
    logic [`SIFH_BIN_W-1:0] winBin;
    logic [`SIFH_BIN_W-1:0] clrAddr;
    logic [StampW-1:0]      stampCnt;
    logic [`SIFH_TS_W-1:0]  stamp;
    logic [`SIFH_BIN_W-1:0] stampBin;
    logic [1:0]             step;               // 0 free, 1 read, 2 wait, 3 write
    logic [`SIFH_CNT_W-1:0] newCnt;

    assign idle = !clearing && !building;

    // new stamp only once the previous update has been written
    assign accept = building && tdcReq && !tdcAck && (step == 2'd0) && (stampCnt != PassLen);

    assign inWindow = !fineMode || (tdcData[`SIFH_TS_W-1 -: `SIFH_BIN_W] == winBin);

    assign stampBin = fineMode ? stamp[`SIFH_BIN_W-1:0] : stamp[`SIFH_TS_W-1 -: `SIFH_BIN_W];
    assign rdAddr   = stampBin;

    always_comb begin
        wr = '0;
        if (clearing) begin
            wr.en   = 1'b1;
            wr.addr = clrAddr;                  // data stays zero
        end else if (step == 2'd3) begin
            wr.en   = 1'b1;
            wr.addr = stampBin;
            wr.data = newCnt;
        end
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            clearing <= 1'b0;
            building <= 1'b0;
            clrAddr  <= '0;
            stampCnt <= '0;
            step     <= 2'd0;
            tdcAck   <= 1'b0;
            histDone <= 1'b0;
        end else begin
            histDone <= 1'b0;
            if (histStart && idle) begin
                clearing <= (histCmd.op == opClear);
                building <= (histCmd.op == opBuild);
                clrAddr  <= '0;
                stampCnt <= '0;
            end
            if (clearing) begin
                clrAddr <= clrAddr + 1'b1;
                if (clrAddr == '1) begin
                    clearing <= 1'b0;
                    histDone <= 1'b1;           // cycle after the last write
                end
            end
            if (accept) begin
                tdcAck   <= 1'b1;
                stampCnt <= stampCnt + 1'b1;
                if (inWindow) begin
                    step <= 2'd1;
                end
            end else if (tdcAck && !tdcReq) begin
                tdcAck <= 1'b0;
            end
            if (step != 2'd0) begin
                step <= step + 1'b1;            // wraps back to free after the write
            end
            // last stamp written and its handshake closed
            if (building && (stampCnt == PassLen) && (step == 2'd0) && !tdcAck) begin
                building <= 1'b0;
                histDone <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (histStart && idle) begin
            fineMode <= histCmd.fine;
            winBin   <= histCmd.window;
        end
        if (accept) begin
            stamp <= tdcData;
        end
        if (step == 2'd2) begin
            newCnt <= (rdData == CntMax) ? rdData : rdData + 1'b1;  // saturate
        end
    end

endmodule

// File: src/peakFinder.sv
`timescale 1ns/1ps
`include "sifh_params.svh"

module peakFinder import sifhPkg::*; (
    input  logic                   clk,
    input  logic                   res,
    input  logic                   scanStart,
    output logic                   scanDone,
    output logic [`SIFH_BIN_W-1:0] rdAddr,
    input  logic [`SIFH_CNT_W-1:0] rdData,
    output logic [`SIFH_BIN_W-1:0] peakBin,
    output logic [`SIFH_CNT_W-1:0] peakCount
);

    logic                   scanning;
    logic                   cmpValid;           // rdData belongs to cmpBin
    logic                   cmpLast;
    logic [`SIFH_BIN_W-1:0] addrCnt;
    logic [`SIFH_BIN_W-1:0] cmpBin;

    assign rdAddr = addrCnt;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            scanning  <= 1'b0;
            cmpValid  <= 1'b0;
            cmpLast   <= 1'b0;
            addrCnt   <= '0;
            scanDone  <= 1'b0;
            peakBin   <= '0;
            peakCount <= '0;
        end else begin
            cmpValid <= scanning;
            cmpLast  <= scanning && (addrCnt == '1);
            if (scanStart && !scanning) begin
                scanning  <= 1'b1;
                addrCnt   <= '0;
                scanDone  <= 1'b0;
                peakBin   <= '0;
                peakCount <= '0;
            end else if (scanning) begin
                addrCnt <= addrCnt + 1'b1;
                if (addrCnt == '1) begin
                    scanning <= 1'b0;
                end
            end
            // strictly greater, so the lowest bin keeps a tie
            if (cmpValid && (rdData > peakCount)) begin
                peakBin   <= cmpBin;
                peakCount <= rdData;
            end
            if (cmpLast) begin
                scanDone <= 1'b1;               // held until the next scan
            end
        end
    end

    always_ff @(posedge clk) begin
        cmpBin <= addrCnt;
    end

endmodule

// File: src/sifhControl.sv
`timescale 1ns/1ps
`include "sifh_params.svh"

module sifhControl import sifhPkg::*; (
    input  logic                   clk,
    input  logic                   res,
    input  logic                   start,
    output logic                   histStart,
    output histCmd_t               histCmd,
    input  logic                   histDone,
    output logic                   scanStart,
    input  logic                   scanDone,
    input  logic [`SIFH_BIN_W-1:0] peakBin,
    input  logic [`SIFH_CNT_W-1:0] peakCount,
    output logic                   resReq,
    output peakResult_t            resData,
    input  logic                   resAck
);

    ctrlState_t             state;
    logic [`SIFH_BIN_W-1:0] winBin;             // coarse peak bin
    logic [`SIFH_CNT_W-1:0] winCount;           // coarse peak count
    logic                   scanFinished;

    // scanDone of the earlier scan is still up while scanStart is high
    assign scanFinished = scanDone && !scanStart;

    // builder samples this together with histStart
    always_comb begin
        histCmd.op     = ((state == sClear0) || (state == sClear1)) ? opClear : opBuild;
        histCmd.fine   = (state == sClear1) || (state == sBuild1);
        histCmd.window = winBin;
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state     <= sIdle;
            histStart <= 1'b0;
            scanStart <= 1'b0;
            resReq    <= 1'b0;
        end else begin
            histStart <= 1'b0;
            scanStart <= 1'b0;
            case (state)
                sIdle: begin
                    if (start) begin
                        state     <= sClear0;
                        histStart <= 1'b1;
                    end
                end
                sClear0: begin
                    if (histDone) begin
                        state     <= sBuild0;
                        histStart <= 1'b1;
                    end
                end
                sBuild0: begin
                    if (histDone) begin
                        state     <= sScan0;
                        scanStart <= 1'b1;
                    end
                end
                sScan0: begin
                    if (scanFinished) begin
                        state <= sWindow;
                    end
                end
                sWindow: begin
                    state     <= sClear1;       // single cycle, window latched
                    histStart <= 1'b1;
                end
                sClear1: begin
                    if (histDone) begin
                        state     <= sBuild1;
                        histStart <= 1'b1;
                    end
                end
                sBuild1: begin
                    if (histDone) begin
                        state     <= sScan1;
                        scanStart <= 1'b1;
                    end
                end
                sScan1: begin
                    if (scanFinished) begin
                        state  <= sResult;
                        resReq <= 1'b1;
                    end
                end
                sResult: begin
                    if (resReq && resAck) begin
                        resReq <= 1'b0;
                    end else if (!resReq && !resAck) begin
                        state <= sIdle;         // handshake fully closed
                    end
                end
                default: begin
                    state <= sIdle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == sWindow) begin
            winBin   <= peakBin;
            winCount <= peakCount;
        end
        // loaded only while resReq is low
        if ((state == sScan1) && scanFinished) begin
            resData.peakTime    <= {winBin, peakBin};
            resData.peakCount   <= peakCount;
            resData.coarseCount <= winCount;
        end
    end

endmodule

// File: src/sifhTop.sv
`timescale 1ns/1ps
`include "sifh_params.svh"

module sifhTop import sifhPkg::*; (
    input  logic                  clk,
    input  logic                  res,
    input  logic                  start,
    input  logic                  tdcReq,
    input  logic [`SIFH_TS_W-1:0] tdcData,
    output logic                  tdcAck,
    output logic                  resReq,
    output peakResult_t           resData,
    input  logic                  resAck
);

    logic                   histStart;
    logic                   histDone;
    histCmd_t               histCmd;
    logic                   scanStart;
    logic                   scanDone;
    logic [`SIFH_BIN_W-1:0] peakBin;
    logic [`SIFH_CNT_W-1:0] peakCount;
    ramWr_t                 ramWr;
    logic [`SIFH_BIN_W-1:0] rdAddrA;            // builder read port
    logic [`SIFH_BIN_W-1:0] rdAddrB;            // scan read port
    logic [`SIFH_CNT_W-1:0] rdDataA;
    logic [`SIFH_CNT_W-1:0] rdDataB;

    sifhControl i_sifhControl (
        .clk       (clk),
        .res       (res),
        .start     (start),
        .histStart (histStart),
        .histCmd   (histCmd),
        .histDone  (histDone),
        .scanStart (scanStart),
        .scanDone  (scanDone),
        .peakBin   (peakBin),
        .peakCount (peakCount),
        .resReq    (resReq),
        .resData   (resData),
        .resAck    (resAck)
    );

    histBuilder i_histBuilder (
        .clk       (clk),
        .res       (res),
        .histStart (histStart),
        .histCmd   (histCmd),
        .histDone  (histDone),
        .tdcReq    (tdcReq),
        .tdcData   (tdcData),
        .tdcAck    (tdcAck),
        .wr        (ramWr),
        .rdAddr    (rdAddrA),
        .rdData    (rdDataA)
    );

    peakFinder i_peakFinder (
        .clk       (clk),
        .res       (res),
        .scanStart (scanStart),
        .scanDone  (scanDone),
        .rdAddr    (rdAddrB),
        .rdData    (rdDataB),
        .peakBin   (peakBin),
        .peakCount (peakCount)
    );

    histRam i_histRam (
        .clk     (clk),
        .wr      (ramWr),
        .rdAddrA (rdAddrA),
        .rdAddrB (rdAddrB),
        .rdDataA (rdDataA),
        .rdDataB (rdDataB)
    );

endmodule

// File: sim/sifhTb.sv
`timescale 1ns/1ps
`include "sifh_params.svh"

module sifhTb import sifhPkg::*; ();

    localparam int NumRows = 9;
    localparam int CntMax  = (1 << `SIFH_CNT_W) - 1;
    localparam int Bins    = 1 << `SIFH_BIN_W;

    typedef struct packed {
        logic [`SIFH_TS_W-1:0] center;
        logic [`SIFH_TS_W-1:0] center2;         // second cluster, zero for none
        logic [`SIFH_TS_W-1:0] jitter;          // low bits randomized inside the cluster
        int                    size;            // cluster stamps per pass
        int                    ackDelay;        // cycles before resAck
        int                    gap;             // idle cycles before each stamp
        bit                    outWin;          // fine pass kept off the window
    } rowCfg_t;

    // center, center2, jitter, size, ackDelay, gap, outWin
    rowCfg_t rows [NumRows] = '{
        '{12'h5A3, 12'h000, 12'h00F, 40, 0, 0, 1'b0},   // dense cluster in noise
        '{12'h2C4, 12'h000, 12'h003, 32, 3, 1, 1'b0},   // narrow fine spread
        '{12'h405, 12'h3C5, 12'h000, 64, 1, 0, 1'b0},   // coarse tie
        '{12'h3C9, 12'h3C5, 12'h000, 64, 0, 0, 1'b0},   // fine tie
        '{12'h7E1, 12'h000, 12'h007, 48, 2, 0, 1'b1},   // empty window
        '{12'hABC, 12'h000, 12'h000, 64, 0, 0, 1'b0},   // saturation
        '{12'hAB0, 12'h000, 12'h00F, 20, 0, 0, 1'b0},   // same bin, fewer stamps
        '{12'h18A, 12'h000, 12'h01F, 36, 12, 9, 1'b0},  // back-pressure
        '{12'h000, 12'h000, 12'h000, 0, 5, 2, 1'b0}     // noise only
    };

    logic                  clk;
    logic                  res;
    logic                  start;
    logic                  tdcReq;
    logic [`SIFH_TS_W-1:0] tdcData;
    logic                  tdcAck;
    logic                  resReq;
    peakResult_t           resData;
    logic                  resAck;

    logic [`SIFH_TS_W-1:0] stampMem [2][`SIFH_PASS_LEN];
    logic [15:0]           lfsrState = 16'd86;
    peakResult_t           got;
    int                    ackRises;
    logic                  ackLast;
    int                    checks;
    int                    errors;

    sifhTop i_sifhTop (
        .clk     (clk),
        .res     (res),
        .start   (start),
        .tdcReq  (tdcReq),
        .tdcData (tdcData),
        .tdcAck  (tdcAck),
        .resReq  (resReq),
        .resData (resData),
        .resAck  (resAck)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // rising edges of the stamp acknowledge
    always @(posedge clk) begin
        if (tdcAck && !ackLast) begin
            ackRises = ackRises + 1;
        end
        ackLast = tdcAck;
    end

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic checkEq(input int actual, input int expected, input string what);
        checks = checks + 1;
        if (actual != expected) begin
            errors = errors + 1;
            $display("CHECK FAILED at %0t ns: %s is %0h, expected %0h",
                     $time, what, actual, expected);
        end
    endtask

    // galois form, taps 16,14,13,11
    function automatic logic lfsrStep();
        logic out;
        out = lfsrState[0];
        lfsrState = {1'b0, lfsrState[15:1]} ^ (out ? 16'hB400 : 16'h0000);
        return out;
    endfunction

    function automatic logic [`SIFH_TS_W-1:0] randBits(input int n);
        logic [`SIFH_TS_W-1:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v = {v[`SIFH_TS_W-2:0], lfsrStep()};
        end
        return v;
    endfunction

    task automatic makeStamps(input int pass, input rowCfg_t cfg,
                              input logic [`SIFH_BIN_W-1:0] avoid);
        logic [`SIFH_TS_W-1:0] s;
        logic [`SIFH_TS_W-1:0] ctr;
        for (int i = 0; i < `SIFH_PASS_LEN; i++) begin
            ctr = ((cfg.center2 != '0) && i[0]) ? cfg.center2 : cfg.center;
            if (i < cfg.size) begin
                s = (ctr & ~cfg.jitter) | (randBits($countones(cfg.jitter)) & cfg.jitter);
            end else begin
                s = randBits(`SIFH_TS_W);
            end
            if ((pass == 1) && cfg.outWin && (s[`SIFH_TS_W-1 -: `SIFH_BIN_W] == avoid)) begin
                s[`SIFH_BIN_W] = ~s[`SIFH_BIN_W];  // move to the neighbor coarse bin
            end
            stampMem[pass][i] = s;
        end
    endtask

    // reference histogram of one pass, returns {bin, count}
    function automatic logic [11:0] histPeak(input int pass, input bit fine,
                                             input logic [`SIFH_BIN_W-1:0] win);
        int          hist [Bins];
        int          bin;
        int          best;
        int          bestCnt;
        logic [`SIFH_TS_W-1:0] s;
        for (int b = 0; b < Bins; b++) begin
            hist[b] = 0;
        end
        for (int i = 0; i < `SIFH_PASS_LEN; i++) begin
            s = stampMem[pass][i];
            bin = -1;
            if (!fine) begin
                bin = int'(s[`SIFH_TS_W-1 -: `SIFH_BIN_W]);
            end else if (s[`SIFH_TS_W-1 -: `SIFH_BIN_W] == win) begin
                bin = int'(s[`SIFH_BIN_W-1:0]);
            end
            if ((bin >= 0) && (hist[bin] < CntMax)) begin
                hist[bin] = hist[bin] + 1;
            end
        end
        best = 0;
        bestCnt = 0;
        for (int b = 0; b < Bins; b++) begin
            if (hist[b] > bestCnt) begin    // lowest bin keeps a tie
                best = b;
                bestCnt = hist[b];
            end
        end
        return {best[5:0], bestCnt[5:0]};
    endfunction

    task automatic sendStamps(input rowCfg_t cfg);
        for (int p = 0; p < 2; p++) begin
            for (int i = 0; i < `SIFH_PASS_LEN; i++) begin
                if ((p == 0) && (i == 10)) begin
                    start = 1'b1;           // frame already running
                    tick();
                    start = 1'b0;
                end
                repeat (cfg.gap) tick();
                tdcData = stampMem[p][i];
                tdcReq = 1'b1;
                tick();
                while (!tdcAck) tick();
                tdcReq = 1'b0;
                tick();
                while (tdcAck) tick();
            end
        end
    endtask

    task automatic takeResult(input int delay);
        while (!resReq) tick();
        got = resData;
        repeat (delay) begin
            tick();
            checkEq(int'(resReq), 1, "resReq held before resAck");
            checkEq(int'(resData), int'(got), "resData while resReq high");
        end
        resAck = 1'b1;
        tick();
        while (resReq) tick();
        resAck = 1'b0;
    endtask

    task automatic runRow(input int r);
        rowCfg_t     cfg;
        logic [11:0] coarse;
        logic [11:0] fine;
        peakResult_t exp;
        int          errBefore;
        cfg = rows[r];
        errBefore = errors;
        makeStamps(0, cfg, '0);
        coarse = histPeak(0, 1'b0, '0);
        makeStamps(1, cfg, coarse[11:6]);
        fine = histPeak(1, 1'b1, coarse[11:6]);
        exp.peakTime = {coarse[11:6], fine[11:6]};
        exp.peakCount = fine[5:0];
        exp.coarseCount = coarse[5:0];
        ackRises = 0;
        start = 1'b1;
        tick();
        start = 1'b0;
        fork
            sendStamps(cfg);
            takeResult(cfg.ackDelay);
        join
        checkEq(int'(got.peakTime), int'(exp.peakTime), "peakTime");
        checkEq(int'(got.peakCount), int'(exp.peakCount), "peakCount");
        checkEq(int'(got.coarseCount), int'(exp.coarseCount), "coarseCount");
        checkEq(ackRises, 2 * `SIFH_PASS_LEN, "stamp acknowledges");
        $display("row %0d: peakTime %03h peakCount %0d coarseCount %0d acks %0d %s",
                 r, got.peakTime, got.peakCount, got.coarseCount, ackRises,
                 (errors == errBefore) ? "ok" : "mismatch");
    endtask

    initial begin
        res = 1'b0;
        start = 1'b0;
        tdcReq = 1'b0;
        tdcData = '0;
        resAck = 1'b0;
        ackRises = 0;
        ackLast = 1'b0;
        checks = 0;
        errors = 0;
        repeat (16) @(posedge clk);
        #1;
        res = 1'b1;
        tick();
        for (int r = 0; r < NumRows; r++) begin
            runRow(r);
            repeat (2) tick();
        end
        $display("rows %0d, checks %0d, errors %0d", NumRows, checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    // stamps at worst case handshake plus clear and scan per pass
    initial begin : watchdog
        longint limit;
        limit = 16 + 1000;
        for (int r = 0; r < NumRows; r++) begin
            limit = limit + 2 * `SIFH_PASS_LEN * (rows[r].gap + 8);
            limit = limit + 2 * (Bins + 1 + Bins + 3) + rows[r].ackDelay + 100;
        end
        #(limit * 8);
        $display("watchdog timeout: rows not finished after %0d cycles", limit);
        $display("Checks failed");
        $finish;
    end

endmodule

// File: sources.f
+incdir+src
src/sifhPkg.sv
src/histRam.sv
src/histBuilder.sv
src/peakFinder.sv
src/sifhControl.sv
src/sifhTop.sv
sim/sifhTb.sv

// File: Makefile
TOP = sifhTb

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): sources.f $(wildcard src/*.sv src/*.svh sim/*.sv)
	verilator --binary --timing --top-module $(TOP) -f sources.f -o V$(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "All checks passed" sim.log

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f sources.f

clean:
	rm -rf obj_dir sim.log
